// ==== rtl/dii_pkg.sv ====
package dii_pkg;

   // ~~~~~~~~~~~~~~~~~~~~
   // sizes
   localparam int FLIT_WIDTH    = 16;  // also the wishbone data width
   localparam int NUM_QUEUES    = 4;
   localparam int QUEUE_DEPTH   = 8;   // flits per buffer
   localparam int QSEL_WIDTH    = 2;   // low destination bits
   localparam int SIZE_WIDTH    = 3;
   localparam int WB_ADDR_WIDTH = 3;

   // ~~~~~~~~~~~~~~~~~~~~
   // flit link
   typedef struct packed {
      logic                  valid;
      logic                  last;
      logic [FLIT_WIDTH-1:0] data;
   } dii_flit;

   // ~~~~~~~~~~~~~~~~~~~~
   // register map, word addresses
   typedef enum logic [WB_ADDR_WIDTH-1:0] {
      REG_FLIT      = 3'd0,
      REG_FLIT_LAST = 3'd1,  // flit that closes its packet
      REG_STATUS    = 3'd4   // queue n at REG_STATUS + n
   } wb_reg_e;

   typedef enum logic {
      ING_HEAD,  // next flit is a destination word
      ING_BODY
   } ingress_state_e;

   typedef enum logic {
      ARB_PICK,
      ARB_SEND
   } arb_state_e;

endpackage

// ==== rtl/dii_wb_ingress.sv ====
module dii_wb_ingress (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  wb_cyc,
   input  logic                                  wb_stb,
   input  logic                                  wb_we,
   input  logic [dii_pkg::WB_ADDR_WIDTH-1:0]     wb_adr,
   input  logic [dii_pkg::FLIT_WIDTH-1:0]        wb_dat_w,
   output logic                                  wb_ack,
   output logic [dii_pkg::FLIT_WIDTH-1:0]        wb_dat_r,
   output dii_pkg::dii_flit                      q_flit [dii_pkg::NUM_QUEUES],
   input  logic [dii_pkg::NUM_QUEUES-1:0]        q_ready,
   input  logic [dii_pkg::SIZE_WIDTH-1:0]        q_size [dii_pkg::NUM_QUEUES]
);

   dii_pkg::ingress_state_e               state;
   logic [dii_pkg::QSEL_WIDTH-1:0]        cur_q;
   logic [dii_pkg::QSEL_WIDTH-1:0]        target;
   logic [dii_pkg::QSEL_WIDTH-1:0]        status_q;
   logic                                  active;
   logic                                  is_flit;
   logic                                  is_last;
   logic                                  is_status;
   logic                                  wr_flit;
   logic                                  push;
   logic                                  other_access;
   logic [dii_pkg::FLIT_WIDTH-1:0]        status_word;

   // the ack cycle itself is not a new transfer
   assign active       = wb_cyc & wb_stb & !wb_ack;
   assign is_last      = (wb_adr == dii_pkg::REG_FLIT_LAST);
   assign is_flit      = (wb_adr == dii_pkg::REG_FLIT) | is_last;
   assign is_status    = (wb_adr >= dii_pkg::REG_STATUS);

   // destination comes from the head flit itself
   assign target       = (state == dii_pkg::ING_HEAD) ?
                         wb_dat_w[dii_pkg::QSEL_WIDTH-1:0] : cur_q;
   assign wr_flit      = active & wb_we & is_flit;
   assign push         = wr_flit & q_ready[target];  // stalls on a full queue
   assign other_access = active & !(wb_we & is_flit);

   always_comb begin : steer
      for (int q = 0; q < dii_pkg::NUM_QUEUES; q++) begin
         q_flit[q].valid = wr_flit & (target == dii_pkg::QSEL_WIDTH'(q));
         q_flit[q].last  = is_last;
         q_flit[q].data  = wb_dat_w;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // status words
   assign status_q = dii_pkg::QSEL_WIDTH'(wb_adr - dii_pkg::REG_STATUS);

   always_comb begin
      status_word = '0;
      status_word[dii_pkg::FLIT_WIDTH-1]   = q_ready[status_q];
      status_word[dii_pkg::SIZE_WIDTH-1:0] = q_size[status_q];
   end

   always_ff @(posedge clk) begin
      if (active & !wb_we) begin
         wb_dat_r <= is_status ? status_word : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_ack <= 1'b0;
         state  <= dii_pkg::ING_HEAD;
         cur_q  <= '0;
      end else begin
         wb_ack <= push | other_access;
         if (push) begin
            if (state == dii_pkg::ING_HEAD) begin
               cur_q <= target;
            end
            state <= is_last ? dii_pkg::ING_HEAD : dii_pkg::ING_BODY;
         end
      end
   end

endmodule

// ==== rtl/dii_buffer.sv ====
module dii_buffer #(
   parameter int WIDTH      = dii_pkg::FLIT_WIDTH,
   parameter int SIZE       = dii_pkg::QUEUE_DEPTH,
   parameter bit FULLPACKET = 1'b0
) (
   input  logic                     clk,
   input  logic                     rst,

   output logic [$clog2(SIZE)-1:0]  packet_size,

   input  dii_pkg::dii_flit         flit_in,
   output logic                     flit_in_ready,
   output dii_pkg::dii_flit         flit_out,
   input  logic                     flit_out_ready
);

   logic [WIDTH-1:0]  mem_data [SIZE];
   logic [SIZE-1:0]   mem_last;
   logic [WIDTH-1:0]  nxt_data [SIZE];
   logic [SIZE-1:0]   nxt_last;
   logic [SIZE:0]     wr_ptr;     // one-hot, bit n means n flits stored
   logic [SIZE-1:0]   occupied;
   logic              push;
   logic              pop;
   logic              full_packet;

   // slot i holds a flit when the pointer sits above it
   always_comb begin : occupancy
      occupied[SIZE-1] = wr_ptr[SIZE];
      for (int i = SIZE - 2; i >= 0; i--) begin
         occupied[i] = wr_ptr[i+1] | occupied[i+1];
      end
   end

   assign full_packet    = |(mem_last & occupied);

   assign push           = flit_in.valid & flit_in_ready;
   assign pop            = flit_out.valid & flit_out_ready;
   assign flit_in_ready  = !wr_ptr[SIZE];

   assign flit_out.valid = FULLPACKET ? full_packet : occupied[0];
   assign flit_out.last  = mem_last[0];
   assign flit_out.data  = mem_data[0];

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= (SIZE+1)'(1);
      end else if (push & !pop) begin
         wr_ptr <= wr_ptr << 1;
      end else if (pop & !push) begin
         wr_ptr <= wr_ptr >> 1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // shift register, head at slot 0
   always_comb begin : shift_next
      for (int i = 0; i < SIZE; i++) begin
         nxt_data[i] = mem_data[i];
         nxt_last[i] = mem_last[i];
         if (pop) begin
            if (push & wr_ptr[i+1]) begin  // tail moves down with the shift
               nxt_data[i] = flit_in.data;
               nxt_last[i] = flit_in.last;
            end else if (i < SIZE - 1) begin
               nxt_data[i] = mem_data[i+1];
               nxt_last[i] = mem_last[i+1];
            end
         end else if (push & wr_ptr[i]) begin
            nxt_data[i] = flit_in.data;
            nxt_last[i] = flit_in.last;
         end
      end
   end

   always_ff @(posedge clk) begin
      mem_data <= nxt_data;
      mem_last <= nxt_last;
   end

   // size of the head packet, lowest stored last flit wins
   always_comb begin : head_size
      packet_size = ($clog2(SIZE))'(1);
      for (int i = SIZE - 2; i >= 0; i--) begin
         if (mem_last[i] & occupied[i]) begin
            packet_size = ($clog2(SIZE))'(i + 1);
         end
      end
   end

endmodule

// ==== rtl/dii_egress_arbiter.sv ====
module dii_egress_arbiter (
   input  logic                             clk,
   input  logic                             rst,
   input  dii_pkg::dii_flit                 q_flit [dii_pkg::NUM_QUEUES],
   output logic [dii_pkg::NUM_QUEUES-1:0]   q_ready,
   output dii_pkg::dii_flit                 out_flit,
   input  logic                             out_ready
);

   dii_pkg::arb_state_e               state;
   logic [dii_pkg::QSEL_WIDTH-1:0]    grant;
   logic [dii_pkg::QSEL_WIDTH-1:0]    ptr;     // first queue to look at
   logic [dii_pkg::QSEL_WIDTH-1:0]    pick_q;
   logic                              found;
   logic                              sending;
   logic                              done;

   // ~~~~~~~~~~~~~~~~~~~~
   // round robin search from ptr
   always_comb begin : pick
      logic [dii_pkg::QSEL_WIDTH-1:0] idx;
      found  = 1'b0;
      pick_q = ptr;
      for (int k = 0; k < dii_pkg::NUM_QUEUES; k++) begin
         idx = ptr + dii_pkg::QSEL_WIDTH'(k);  // wraps at NUM_QUEUES
         if (!found && q_flit[idx].valid) begin
            found  = 1'b1;
            pick_q = idx;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // output mux and ready steering
   assign sending = (state == dii_pkg::ARB_SEND);

   always_comb begin : route
      out_flit       = q_flit[grant];
      out_flit.valid = sending & q_flit[grant].valid;
      q_ready        = '0;
      q_ready[grant] = sending & out_ready;
   end

   assign done = out_flit.valid & out_ready & out_flit.last;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= dii_pkg::ARB_PICK;
         grant <= '0;
         ptr   <= '0;
      end else begin
         case (state)
            dii_pkg::ARB_PICK: begin
               if (found) begin
                  grant <= pick_q;
                  ptr   <= pick_q + 1'b1;
                  state <= dii_pkg::ARB_SEND;
               end
            end
            dii_pkg::ARB_SEND: begin
               if (done) state <= dii_pkg::ARB_PICK;  // packet fully out
            end
            default: state <= dii_pkg::ARB_PICK;
         endcase
      end
   end

endmodule

// ==== rtl/dii_queue_hub.sv ====
module dii_queue_hub (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              wb_cyc,
   input  logic                              wb_stb,
   input  logic                              wb_we,
   input  logic [dii_pkg::WB_ADDR_WIDTH-1:0] wb_adr,
   input  logic [dii_pkg::FLIT_WIDTH-1:0]    wb_dat_w,
   output logic                              wb_ack,
   output logic [dii_pkg::FLIT_WIDTH-1:0]    wb_dat_r,
   output dii_pkg::dii_flit                  out_flit,
   input  logic                              out_ready
);

   dii_pkg::dii_flit                        in_flit  [dii_pkg::NUM_QUEUES];
   dii_pkg::dii_flit                        buf_flit [dii_pkg::NUM_QUEUES];
   logic [dii_pkg::NUM_QUEUES-1:0]          in_ready;
   logic [dii_pkg::NUM_QUEUES-1:0]          buf_ready;
   logic [dii_pkg::SIZE_WIDTH-1:0]          buf_size [dii_pkg::NUM_QUEUES];

   dii_wb_ingress i_ingress (
      .clk      (clk),
      .rst      (rst),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_ack   (wb_ack),
      .wb_dat_r (wb_dat_r),
      .q_flit   (in_flit),
      .q_ready  (in_ready),
      .q_size   (buf_size)
   );

   // one packet buffer per destination
   for (genvar q = 0; q < dii_pkg::NUM_QUEUES; q++) begin : gen_buf
      dii_buffer #(
         .WIDTH      (dii_pkg::FLIT_WIDTH),
         .SIZE       (dii_pkg::QUEUE_DEPTH),
         .FULLPACKET (1'b1)
      ) i_buffer (
         .clk            (clk),
         .rst            (rst),
         .packet_size    (buf_size[q]),
         .flit_in        (in_flit[q]),
         .flit_in_ready  (in_ready[q]),
         .flit_out       (buf_flit[q]),
         .flit_out_ready (buf_ready[q])
      );
   end

   dii_egress_arbiter i_arbiter (
      .clk       (clk),
      .rst       (rst),
      .q_flit    (buf_flit),
      .q_ready   (buf_ready),
      .out_flit  (out_flit),
      .out_ready (out_ready)
   );

endmodule

// ==== tests/dii_clk_gen.sv ====
module dii_clk_gen #(
   parameter int PERIOD_NS = 40
) (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial clk = 1'b0;
   always #(PERIOD_NS / 2) clk = !clk;

endmodule

// ==== tests/dii_queue_hub_chk.sv ====
module dii_queue_hub_chk (
   input logic                           clk,
   input logic                           rst,
   input logic                           wb_cyc,
   input logic                           wb_stb,
   input logic                           wb_ack,
   input dii_pkg::dii_flit               out_flit,
   input logic                           out_ready,
   input logic [dii_pkg::NUM_QUEUES-1:0] buf_ready
);
   timeunit 1ns;
   timeprecision 100ps;

   ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
      wb_ack |-> wb_cyc && wb_stb)
      else $error("wb_ack raised outside an active bus cycle");

   // held flit may not change until the sink takes it
   out_stable: assert property (@(posedge clk) disable iff (rst)
      out_flit.valid && !out_ready |=> $stable(out_flit))
      else $error("out_flit changed while stalled");

   // the one ready buffer is the one whose flit sits on the output
   one_ready: assert property (@(posedge clk) disable iff (rst)
      $onehot0(buf_ready) && (buf_ready == '0 || out_flit.valid))
      else $error("buffer ready high for several buffers or with no flit on the output");

endmodule

bind dii_queue_hub dii_queue_hub_chk i_chk (
   .clk       (clk),
   .rst       (rst),
   .wb_cyc    (wb_cyc),
   .wb_stb    (wb_stb),
   .wb_ack    (wb_ack),
   .out_flit  (out_flit),
   .out_ready (out_ready),
   .buf_ready (buf_ready)
);

// ==== tests/dii_queue_hub_tb.sv ====
module dii_queue_hub_tb;
   timeunit 1ns;
   timeprecision 100ps;

   logic                              clk;
   logic                              rst;
   logic                              wb_cyc;
   logic                              wb_stb;
   logic                              wb_we;
   logic [dii_pkg::WB_ADDR_WIDTH-1:0] wb_adr;
   logic [dii_pkg::FLIT_WIDTH-1:0]    wb_dat_w;
   logic                              wb_ack;
   logic [dii_pkg::FLIT_WIDTH-1:0]    wb_dat_r;
   dii_pkg::dii_flit                  out_flit;
   logic                              out_ready;

   logic [dii_pkg::FLIT_WIDTH:0]      exp_q [dii_pkg::NUM_QUEUES][$];  // {last, data}
   int                                got_dest [$];  // destination of each packet out
   logic [dii_pkg::QSEL_WIDTH-1:0]    cur_dest;
   logic                              in_pkt = 1'b0;
   bit                                bp_stop;
   int                                check_count = 0;
   int                                err_count = 0;

   dii_clk_gen i_clk_gen (.clk(clk));

   dii_queue_hub i_dii_queue_hub (.*);

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         err_count++;
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // wishbone host, ack is held through one more rising edge
   task automatic bus_access(input logic we, input logic [dii_pkg::WB_ADDR_WIDTH-1:0] adr,
                             input logic [dii_pkg::FLIT_WIDTH-1:0] wdat,
                             output logic [dii_pkg::FLIT_WIDTH-1:0] rdat);
      int n;
      n = 0;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = we;
      wb_adr = adr;
      wb_dat_w = wdat;
      do begin
         @(negedge clk);
         n++;
      end while (!wb_ack && n < 150);  // a full queue may stall for a while
      if (!wb_ack) begin
         $display("bus access to address %0d was never acknowledged", adr);
         err_count++;
      end
      rdat = wb_dat_r;
      if (!we) check("wb_ack cycles", 32'(n), 32'd1);  // reads answer one cycle after stb
      @(negedge clk);
      check("wb_ack", 32'(wb_ack), 32'h0);  // ack lasts one clock
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
   endtask

   task automatic send_packet(input logic [dii_pkg::QSEL_WIDTH-1:0] dest, input int len,
                              input logic [dii_pkg::FLIT_WIDTH-1:0] base, input bit rnd);
      logic [dii_pkg::FLIT_WIDTH-1:0] data;
      logic [dii_pkg::FLIT_WIDTH-1:0] unused;
      logic last;
      for (int i = 0; i < len; i++) begin
         data = rnd ? 16'($urandom) : base + 16'(i);
         if (i == 0) data[dii_pkg::QSEL_WIDTH-1:0] = dest;  // destination word
         last = (i == len - 1);
         exp_q[dest].push_back({last, data});
         bus_access(1'b1, last ? dii_pkg::REG_FLIT_LAST : dii_pkg::REG_FLIT, data, unused);
      end
   endtask

   function automatic bit queues_empty();
      for (int q = 0; q < dii_pkg::NUM_QUEUES; q++) begin
         if (exp_q[q].size() != 0) return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic wait_drain();
      int n;
      n = 0;
      while ((!queues_empty() || in_pkt) && n < 400) begin
         @(negedge clk);
         n++;
      end
      if (n >= 400) begin
         $display("expected packets never left the hub");
         err_count++;
      end
   endtask

   // scoreboard, every flit out is matched against its destination's queue
   task automatic collect_output();
      logic [dii_pkg::FLIT_WIDTH:0] exp;
      forever begin
         @(posedge clk);
         if (out_flit.valid && out_ready) begin
            if (!in_pkt) cur_dest = out_flit.data[dii_pkg::QSEL_WIDTH-1:0];
            if (exp_q[cur_dest].size() == 0) begin
               $display("flit 0x%0h left for queue %0d with none expected",
                        out_flit.data, cur_dest);
               err_count++;
            end else begin
               exp = exp_q[cur_dest].pop_front();
               check("out_flit.data", 32'(out_flit.data), 32'(exp[dii_pkg::FLIT_WIDTH-1:0]));
               check("out_flit.last", 32'(out_flit.last), 32'(exp[dii_pkg::FLIT_WIDTH]));
            end
            in_pkt = !out_flit.last;
            if (out_flit.last) got_dest.push_back(int'(cur_dest));
         end
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // directed tests
   task automatic reset_state();
      logic [dii_pkg::FLIT_WIDTH-1:0] rdat;
      check("out_flit.valid", 32'(out_flit.valid), 32'h0);
      for (int q = 0; q < dii_pkg::NUM_QUEUES; q++) begin
         bus_access(1'b0, dii_pkg::REG_STATUS + 3'(q), '0, rdat);
         check("wb_dat_r", 32'(rdat), 32'h8001);  // ready, size 1
      end
   endtask

   task automatic single_packet();
      out_ready = 1'b1;
      got_dest.delete();
      send_packet(2'd2, 3, 16'h2a00, 1'b0);
      wait_drain();
      check("packets out", 32'(got_dest.size()), 32'd1);
      check("packet queue", 32'(got_dest[0]), 32'd2);
   endtask

   task automatic round_robin_order();
      out_ready = 1'b0;
      got_dest.delete();
      send_packet(2'd3, 2, 16'h3b00, 1'b0);
      send_packet(2'd1, 4, 16'h1c00, 1'b0);
      send_packet(2'd0, 3, 16'h0d00, 1'b0);
      out_ready = 1'b1;
      wait_drain();
      // queue 3 is granted as soon as it completes, then the pointer moves on to 0
      check("packets out", 32'(got_dest.size()), 32'd3);
      check("packet queue", 32'(got_dest[0]), 32'd3);
      check("packet queue", 32'(got_dest[1]), 32'd0);
      check("packet queue", 32'(got_dest[2]), 32'd1);
   endtask

   task automatic status_words();
      logic [dii_pkg::FLIT_WIDTH-1:0] rdat;
      out_ready = 1'b0;
      send_packet(2'd1, 5, 16'h5100, 1'b0);
      bus_access(1'b0, dii_pkg::REG_STATUS + 3'd1, '0, rdat);
      check("wb_dat_r", 32'(rdat), 32'h8005);
      send_packet(2'd1, 3, 16'h6100, 1'b0);  // buffer now full
      bus_access(1'b0, dii_pkg::REG_STATUS + 3'd1, '0, rdat);
      check("wb_dat_r", 32'(rdat), 32'h0005);
      out_ready = 1'b1;
      wait_drain();
   endtask

   task automatic random_traffic();
      got_dest.delete();
      bp_stop = 1'b0;
      fork
         while (!bp_stop) begin
            @(negedge clk);
            out_ready = 1'($urandom_range(1, 0));
         end
         begin
            for (int p = 0; p < 20; p++) begin
               send_packet(2'($urandom_range(3, 0)), int'($urandom_range(7, 1)), '0, 1'b1);
            end
            wait_drain();
            bp_stop = 1'b1;
         end
      join
      out_ready = 1'b1;
      check("packets out", 32'(got_dest.size()), 32'd20);
   endtask

   initial begin
      void'($urandom(32'hf5aa_d884));
      rst = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      out_ready = 1'b0;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      fork
         collect_output();
      join_none
      reset_state();
      single_packet();
      round_robin_order();
      status_words();
      random_traffic();
      $display("checks %0d, errors %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (4 + 5 * 200) @(posedge clk);  // reset plus five tests of 200 cycles
      $display("simulation ran out of time");
      $display("Something failed");
      $finish;
   end

endmodule

// ==== verilog.f ====
rtl/dii_pkg.sv
rtl/dii_wb_ingress.sv
rtl/dii_buffer.sv
rtl/dii_egress_arbiter.sv
rtl/dii_queue_hub.sv
tests/dii_clk_gen.sv
tests/dii_queue_hub_chk.sv
tests/dii_queue_hub_tb.sv

// ==== Bender.yml ====
package:
  name: dii_queue_hub

sources:
  - rtl/dii_pkg.sv
  - rtl/dii_wb_ingress.sv
  - rtl/dii_buffer.sv
  - rtl/dii_egress_arbiter.sv
  - rtl/dii_queue_hub.sv
  - target: test
    files:
      - tests/dii_clk_gen.sv
      - tests/dii_queue_hub_chk.sv
      - tests/dii_queue_hub_tb.sv
